//--- Makefile
VERILATOR ?= verilator
TOP       := tb_sdd_ld_top
FILELIST  := sdd_ld_top.f
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sdd_ld_config.svh
`ifndef SDD_LD_CONFIG_SVH
`define SDD_LD_CONFIG_SVH

// Lanes per word and payload bits per word
`define SDD_LANES 32

// Extra window bits past the word so the upper lanes see a whole code
`define SDD_LOOKAHEAD 8

// Longest canonical code
`define SDD_MAX_CODE_BITS 8

// Symbol lookup entries per bank
`define SDD_SLT_DEPTH 32

// Raw literals are this wide too
`define SDD_SYM_BITS 8

`endif

//--- sdd_ld_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdd_ld_config.svh"

module sdd_ld_lane #(
   parameter int LANE_IDX = 0
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          advance,
   input  logic                          s1_valid,
   input  sdd_ld_pkg::word_t             s1_word,
   input  sdd_ld_pkg::code_table_t [1:0] tables,
   output logic                          s3_valid,
   output sdd_ld_pkg::word_t             s3_word,
   output sdd_ld_pkg::lane_res_t         res
);

   sdd_ld_pkg::code_table_t tab1;
   sdd_ld_pkg::code_table_t tab2;
   sdd_ld_pkg::code_t       peek;

   logic                    hit;
   logic [3:0]              len_d;
   sdd_ld_pkg::slt_idx_t    idx_d;

   logic                    s2_valid;
   sdd_ld_pkg::word_t       s2_word;
   logic [3:0]              s2_len;
   sdd_ld_pkg::slt_idx_t    s2_idx;
   sdd_ld_pkg::lane_err_e   s2_err;
   sdd_ld_pkg::lane_res_t   res_d;

   assign tab1 = tables[s1_word.bank];
   assign tab2 = tables[s2_word.bank];

   // First stream bit of the lane becomes the code MSB
   always_comb begin
      for (int k = 0; k < `SDD_MAX_CODE_BITS; k++) begin
         peek[`SDD_MAX_CODE_BITS-1-k] = s1_word.window[LANE_IDX+k];
      end
   end

   // Shortest length whose offset from the first code is inside the count
   always_comb begin
      sdd_ld_pkg::code_t    code;
      logic [8:0]           diff;
      sdd_ld_pkg::slt_cnt_t sum;
      hit   = 1'b0;
      len_d = '0;
      idx_d = '0;
      for (int l = 1; l <= `SDD_MAX_CODE_BITS; l++) begin
         code = peek >> (`SDD_MAX_CODE_BITS - l);
         diff = {1'b0, code} - {1'b0, tab1.first[l]};
         sum  = tab1.base[l] + sdd_ld_pkg::slt_cnt_t'(diff);
         if (!hit && !diff[8] && (diff < 9'(tab1.count[l]))) begin
            hit   = 1'b1;
            len_d = 4'(l);
            idx_d = sum[$bits(idx_d)-1:0];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s2_valid <= 1'b0;
         s3_valid <= 1'b0;
      end else if (advance) begin
         s2_valid <= s1_valid;
         s3_valid <= s2_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         s2_word <= s1_word;
         s2_len  <= len_d;
         s2_idx  <= idx_d;
         s2_err  <= hit ? sdd_ld_pkg::ERR_NONE : sdd_ld_pkg::ERR_INVALID_CODE;
      end
   end

   always_comb begin
      logic [6:0] lane_end;
      logic [8:0] eidx;
      res_d.sym = tab2.slt[s2_idx];
      res_d.len = s2_len;
      res_d.err = s2_err;
      res_d.eob = 1'b0;
      // Raw blocks carry plain literals, so every lane is a valid 8-bit symbol
      if (tab2.fmt == sdd_ld_pkg::FMT_RAW) begin
         res_d.sym = s2_word.window[LANE_IDX +: `SDD_SYM_BITS];
         res_d.len = 4'(`SDD_SYM_BITS);
         res_d.err = sdd_ld_pkg::ERR_NONE;
      end
      lane_end = 7'(LANE_IDX) + 7'(res_d.len);
      if (lane_end > 7'(s2_word.numbits)) begin
         if (res_d.err == sdd_ld_pkg::ERR_NONE) begin
            res_d.err = sdd_ld_pkg::ERR_END_MISMATCH;
         end
      end else if (lane_end == 7'(s2_word.numbits)) begin
         res_d.eob = s2_word.eob;
      end
      if (res_d.err != sdd_ld_pkg::ERR_NONE) begin
         res_d.eob = 1'b1;
      end
      eidx = 9'({s2_word.word_mod, 5'd0}) + 9'(lane_end);
      if (res_d.eob && (eidx[4:0] != 5'd0)) begin
         eidx = {eidx[8:5] + 4'd1, 5'd0}; // Next word boundary
      end
      res_d.end_idx = eidx;
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         s3_word <= s2_word;
         res     <= res_d;
      end
   end

endmodule

`default_nettype wire

//--- sdd_ld_lane_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdd_ld_config.svh"

module sdd_ld_lane_collect (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      s3_valid,
   input  sdd_ld_pkg::word_t                         s3_word,
   input  sdd_ld_pkg::lane_res_t [`SDD_LANES-1:0]    lanes_in,
   input  logic                                      out_ready,
   output logic                                      out_valid,
   output sdd_ld_pkg::word_t                         out_word,
   output sdd_ld_pkg::lane_res_t [`SDD_LANES-1:0]    out_lanes,
   output logic [`SDD_LANES-1:0]                     out_err_mask,
   output logic                                      blk_done
);

   logic                  adv;
   logic                  fire;
   logic                  credited_q;
   logic                  credited_d;
   logic [`SDD_LANES-1:0] err_mask_d;

   assign adv  = !out_valid || out_ready;
   assign fire = out_valid && out_ready;

   // A new block reopens the credit before its own eob is looked at
   assign credited_d = credited_q && !out_word.sob;
   assign blk_done   = fire && out_word.eob && !credited_d;

   always_comb begin
      for (int i = 0; i < `SDD_LANES; i++) begin
         err_mask_d[i] = lanes_in[i].err != sdd_ld_pkg::ERR_NONE;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         credited_q <= 1'b0;
      end else begin
         if (adv) begin
            out_valid <= s3_valid;
         end
         if (fire) begin
            credited_q <= credited_d || blk_done;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (adv) begin
         out_word     <= s3_word;
         out_lanes    <= lanes_in;
         out_err_mask <= err_mask_d;
      end
   end

endmodule

`default_nettype wire

//--- sdd_ld_pkg.sv
`default_nettype none

`include "sdd_ld_config.svh"

package sdd_ld_pkg;

   typedef enum logic {
      FMT_RAW  = 1'b0,
      FMT_HUFF = 1'b1
   } fmt_e;

   typedef enum logic [1:0] {
      CFG_FMT = 2'd0, // value[0] is the format
      CFG_LEN = 2'd1, // idx is the length, value[15:8] first code, value[7:0] count
      CFG_SYM = 2'd2  // idx is the entry, value[7:0] the symbol
   } cfg_op_e;

   typedef enum logic [1:0] {
      ERR_NONE         = 2'd0,
      ERR_INVALID_CODE = 2'd1,
      ERR_END_MISMATCH = 2'd2
   } lane_err_e;

   typedef logic [`SDD_MAX_CODE_BITS-1:0]   code_t;
   typedef logic [`SDD_SYM_BITS-1:0]        sym_t;
   typedef logic [$clog2(`SDD_SLT_DEPTH)-1:0] slt_idx_t;
   typedef logic [$clog2(`SDD_SLT_DEPTH):0] slt_cnt_t; // Holds a full count of DEPTH

   typedef struct packed {
      cfg_op_e     op;
      logic        bank;
      logic [4:0]  idx;
      logic [15:0] value;
   } cfg_t;

   typedef struct packed {
      logic [`SDD_LANES+`SDD_LOOKAHEAD-1:0] window;
      logic [5:0]                           numbits;
      logic                                 sob;
      logic                                 eob;
   } in_word_t;

   typedef struct packed {
      logic [`SDD_LANES+`SDD_LOOKAHEAD-1:0] window;
      logic [5:0]                           numbits;
      logic                                 sob;
      logic                                 eob;
      logic                                 bank;
      logic [2:0]                           word_mod;
   } word_t;

   typedef struct packed {
      fmt_e                                 fmt;
      code_t    [`SDD_MAX_CODE_BITS:1]      first;
      slt_cnt_t [`SDD_MAX_CODE_BITS:1]      count;
      slt_cnt_t [`SDD_MAX_CODE_BITS:1]      base;
      sym_t     [`SDD_SLT_DEPTH-1:0]        slt;
   } code_table_t;

   typedef struct packed {
      sym_t       sym;
      logic [3:0] len;
      lane_err_e  err;
      logic       eob;
      logic [8:0] end_idx;
   } lane_res_t;

endpackage

`default_nettype wire

//--- sdd_ld_table_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdd_ld_config.svh"

module sdd_ld_table_store (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          cfg_stb,
   input  sdd_ld_pkg::cfg_t              cfg,
   output sdd_ld_pkg::code_table_t [1:0] tables
);

   sdd_ld_pkg::fmt_e     fmt_q   [2];
   sdd_ld_pkg::slt_cnt_t count_q [2][1:`SDD_MAX_CODE_BITS];
   sdd_ld_pkg::code_t    first_q [2][1:`SDD_MAX_CODE_BITS];
   sdd_ld_pkg::sym_t     slt_q   [2][`SDD_SLT_DEPTH];

   logic [3:0] len_sel;
   logic       len_ok;

   assign len_sel = cfg.idx[3:0];
   assign len_ok  = (cfg.idx != 5'd0) && (cfg.idx <= 5'(`SDD_MAX_CODE_BITS));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < 2; b++) begin
            fmt_q[b] <= sdd_ld_pkg::FMT_RAW;
            for (int l = 1; l <= `SDD_MAX_CODE_BITS; l++) begin
               count_q[b][l] <= '0;
            end
         end
      end else if (cfg_stb) begin
         case (cfg.op)
            sdd_ld_pkg::CFG_FMT: fmt_q[cfg.bank] <= sdd_ld_pkg::fmt_e'(cfg.value[0]);
            sdd_ld_pkg::CFG_LEN: begin
               if (len_ok) begin
                  count_q[cfg.bank][len_sel] <= sdd_ld_pkg::slt_cnt_t'(cfg.value[7:0]);
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_stb && cfg.op == sdd_ld_pkg::CFG_LEN && len_ok) begin
         first_q[cfg.bank][len_sel] <= cfg.value[15:8];
      end
      if (cfg_stb && cfg.op == sdd_ld_pkg::CFG_SYM) begin
         slt_q[cfg.bank][cfg.idx] <= cfg.value[7:0];
      end
   end

   // Base index counts the entries of all shorter lengths
   always_comb begin
      sdd_ld_pkg::slt_cnt_t run;
      for (int b = 0; b < 2; b++) begin
         run = '0;
         tables[b].fmt = fmt_q[b];
         for (int l = 1; l <= `SDD_MAX_CODE_BITS; l++) begin
            tables[b].first[l] = first_q[b][l];
            tables[b].count[l] = count_q[b][l];
            tables[b].base[l]  = run;
            run = run + count_q[b][l];
         end
         for (int e = 0; e < `SDD_SLT_DEPTH; e++) begin
            tables[b].slt[e] = slt_q[b][e];
         end
      end
   end

endmodule

`default_nettype wire

//--- sdd_ld_top.f
+incdir+.
sdd_ld_pkg.sv
sdd_ld_table_store.sv
sdd_ld_word_ingest.sv
sdd_ld_lane.sv
sdd_ld_lane_collect.sv
sdd_ld_top.sv
tb_sdd_ld_top.sv

//--- sdd_ld_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdd_ld_config.svh"

module sdd_ld_top (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   in_valid,
   input  sdd_ld_pkg::in_word_t                   in_word,
   output logic                                   in_ready,
   input  logic                                   cfg_stb,
   input  sdd_ld_pkg::cfg_t                       cfg,
   output logic                                   out_valid,
   output sdd_ld_pkg::word_t                      out_word,
   output sdd_ld_pkg::lane_res_t [`SDD_LANES-1:0] out_lanes,
   output logic [`SDD_LANES-1:0]                  out_err_mask,
   input  logic                                   out_ready,
   output logic                                   blk_done
);

   logic                                   advance;
   sdd_ld_pkg::code_table_t [1:0]          tables;
   logic                                   s1_valid;
   sdd_ld_pkg::word_t                      s1_word;
   logic [`SDD_LANES-1:0]                  s3_valid_vec;
   sdd_ld_pkg::word_t [`SDD_LANES-1:0]     s3_word_vec;
   sdd_ld_pkg::lane_res_t [`SDD_LANES-1:0] lane_res;

   // Whole pipeline moves together
   assign advance = !out_valid || out_ready;

   sdd_ld_table_store table_store_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .cfg_stb (cfg_stb),
      .cfg     (cfg),
      .tables  (tables)
   );

   sdd_ld_word_ingest word_ingest_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_word_data (in_word),
      .in_ready     (in_ready),
      .advance      (advance),
      .s1_valid     (s1_valid),
      .s1_word      (s1_word)
   );

   for (genvar i = 0; i < `SDD_LANES; i++) begin : g_lane
      sdd_ld_lane #(
         .LANE_IDX (i)
      ) lane_i (
         .clk      (clk),
         .rst_n    (rst_n),
         .advance  (advance),
         .s1_valid (s1_valid),
         .s1_word  (s1_word),
         .tables   (tables),
         .s3_valid (s3_valid_vec[i]),
         .s3_word  (s3_word_vec[i]),
         .res      (lane_res[i])
      );
   end

   // Lanes run in lockstep so lane 0 speaks for the word
   sdd_ld_lane_collect lane_collect_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .s3_valid     (s3_valid_vec[0]),
      .s3_word      (s3_word_vec[0]),
      .lanes_in     (lane_res),
      .out_ready    (out_ready),
      .out_valid    (out_valid),
      .out_word     (out_word),
      .out_lanes    (out_lanes),
      .out_err_mask (out_err_mask),
      .blk_done     (blk_done)
   );

endmodule

`default_nettype wire

//--- sdd_ld_word_ingest.sv
`timescale 1ns/1ps
`default_nettype none

module sdd_ld_word_ingest (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  sdd_ld_pkg::in_word_t   in_word_data,
   output logic                   in_ready,
   input  logic                   advance,
   output logic                   s1_valid,
   output sdd_ld_pkg::word_t      s1_word
);

   logic       accept;
   logic       bank_q;
   logic       bank_d;
   logic [2:0] word_mod_q;
   logic [2:0] word_mod_d;

   assign in_ready = advance;
   assign accept   = in_valid && advance;

   // A new block switches to the other table bank
   assign bank_d     = bank_q ^ in_word_data.sob;
   assign word_mod_d = in_word_data.sob ? 3'd0 : word_mod_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bank_q     <= 1'b1; // First sob lands on bank 0
         word_mod_q <= 3'd0;
         s1_valid   <= 1'b0;
      end else begin
         if (advance) begin
            s1_valid <= in_valid;
         end
         if (accept) begin
            bank_q     <= bank_d;
            word_mod_q <= word_mod_d + 3'd1; // Wraps modulo 8
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         s1_word.window   <= in_word_data.window;
         s1_word.numbits  <= in_word_data.numbits;
         s1_word.sob      <= in_word_data.sob;
         s1_word.eob      <= in_word_data.eob;
         s1_word.bank     <= bank_d;
         s1_word.word_mod <= word_mod_d;
      end
   end

endmodule

`default_nettype wire

//--- tb_sdd_ld_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdd_ld_config.svh"

module tb_sdd_ld_top;

   localparam int NROWS = 20;

   typedef struct packed {
      logic       huff; // Huffman coded block when set
      logic       sob;
      logic       eob;
      logic [5:0] nb;
      logic       bp;   // Random out_ready while this row is driven
      logic       ones; // Window forced to all ones
   } row_t;

   logic                                   clk;
   logic                                   rst_n;
   logic                                   in_valid;
   sdd_ld_pkg::in_word_t                   in_word;
   logic                                   in_ready;
   logic                                   cfg_stb;
   sdd_ld_pkg::cfg_t                       cfg;
   logic                                   out_valid;
   sdd_ld_pkg::word_t                      out_word;
   sdd_ld_pkg::lane_res_t [`SDD_LANES-1:0] out_lanes;
   logic [`SDD_LANES-1:0]                  out_err_mask;
   logic                                   out_ready;
   logic                                   blk_done;

   row_t rows [NROWS] = '{
      '{1'b1, 1'b1, 1'b0, 6'd32, 1'b0, 1'b0},
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b0, 1'b1},
      '{1'b1, 1'b0, 1'b1, 6'd20, 1'b0, 1'b0},
      '{1'b0, 1'b1, 1'b0, 6'd32, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b1, 6'd29, 1'b0, 1'b0},
      '{1'b1, 1'b1, 1'b0, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b1, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b1, 6'd16, 1'b1, 1'b0}, // Second eob gives no new pulse
      '{1'b0, 1'b1, 1'b1, 6'd24, 1'b1, 1'b1},
      '{1'b1, 1'b1, 1'b0, 6'd32, 1'b1, 1'b0}, // Ten words so word_mod wraps
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b0, 6'd32, 1'b0, 1'b0},
      '{1'b1, 1'b0, 1'b1, 6'd8,  1'b0, 1'b0}
   };

   // Length 4 starts at 1011, shadowed by 101, so 1111 stays unused
   int         hf_first [1:8] = '{0, 0, 4, 11, 0, 0, 0, 0};
   int         hf_count [1:8] = '{0, 2, 2, 4, 0, 0, 0, 0};
   logic [7:0] hf_sym   [8]   = '{8'h3a, 8'h05, 8'hc4, 8'h71, 8'h9e, 8'h22, 8'hd8, 8'h6b};

   logic [31:0] lfsr = 32'hbef5_b6bd;
   logic [39:0] wins [NROWS];
   int          acc_cyc [NROWS];
   int          cyc = 0;
   int          last_hold = -1;
   int          n_out = 0;
   int          errors = 0;
   logic        bp_mode = 1'b0;
   logic        exp_credit = 1'b0;
   logic [2:0]  wm_next = 3'd0;

   sdd_ld_top dut_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_word      (in_word),
      .in_ready     (in_ready),
      .cfg_stb      (cfg_stb),
      .cfg          (cfg),
      .out_valid    (out_valid),
      .out_word     (out_word),
      .out_lanes    (out_lanes),
      .out_err_mask (out_err_mask),
      .out_ready    (out_ready),
      .blk_done     (blk_done)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      forever begin
         @(posedge clk);
         cyc = cyc + 1;
      end
   end

   function logic next_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;
      return b;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_eq(input string what, input logic [63:0] act, input logic [63:0] exp);
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s actual %0h expected %0h", $time, what, act, exp);
         $display("sim failed");
         $fatal(1, "mismatch on %s", what);
      end
   endtask

   // Expected lane result from the canonical code rules
   function automatic sdd_ld_pkg::lane_res_t predict_lane(input int lane, input logic [39:0] w,
      input logic huff, input logic [5:0] nb, input logic eob, input logic [2:0] wm);
      sdd_ld_pkg::lane_res_t r;
      int code;
      int start;
      int lend;
      int eidx;
      r = '0;
      r.err = sdd_ld_pkg::ERR_INVALID_CODE;
      code = 0;
      start = 0;
      if (huff) begin
         for (int l = 1; l <= 8; l++) begin
            code = code * 2 + int'(w[lane+l-1]);
            if (r.len == 4'd0 && code >= hf_first[l] && code - hf_first[l] < hf_count[l]) begin
               r.len = 4'(l);
               r.err = sdd_ld_pkg::ERR_NONE;
               r.sym = hf_sym[start + code - hf_first[l]];
            end
            start = start + hf_count[l];
         end
      end else begin
         for (int k = 0; k < 8; k++) r.sym[k] = w[lane+k]; // Lowest bit first
         r.len = 4'd8;
         r.err = sdd_ld_pkg::ERR_NONE;
      end
      lend = lane + int'(r.len);
      if (lend > int'(nb)) begin
         if (r.err == sdd_ld_pkg::ERR_NONE) r.err = sdd_ld_pkg::ERR_END_MISMATCH;
      end else if (lend == int'(nb)) begin
         r.eob = eob;
      end
      if (r.err != sdd_ld_pkg::ERR_NONE) r.eob = 1'b1;
      eidx = int'(wm) * 32 + lend;
      if (r.eob && (eidx % 32) != 0) eidx = (eidx / 32 + 1) * 32;
      r.end_idx = 9'(eidx);
      return r;
   endfunction

   task automatic check_word(input int n);
      row_t                  r;
      sdd_ld_pkg::lane_res_t e;
      logic [2:0]            wm;
      logic                  exp_done;
      logic [31:0]           exp_mask;
      if (n >= NROWS) abort_run("DUT produced more words than were sent");
      r = rows[n];
      exp_credit = exp_credit && !r.sob;
      wm = r.sob ? 3'd0 : wm_next;
      wm_next = wm + 3'd1;
      exp_done = r.eob && !exp_credit;
      if (exp_done) exp_credit = 1'b1;
      check_eq("out_word.bank", 64'(out_word.bank), 64'(!r.huff));
      check_eq("out_word.sob", 64'(out_word.sob), 64'(r.sob));
      check_eq("out_word.eob", 64'(out_word.eob), 64'(r.eob));
      check_eq("out_word.numbits", 64'(out_word.numbits), 64'(r.nb));
      check_eq("out_word.word_mod", 64'(out_word.word_mod), 64'(wm));
      check_eq("out_word.window", 64'(out_word.window), 64'(wins[n]));
      check_eq("blk_done", 64'(blk_done), 64'(exp_done));
      if (last_hold < acc_cyc[n]) check_eq("latency", 64'(cyc - acc_cyc[n]), 64'd4);
      exp_mask = '0;
      for (int i = 0; i < `SDD_LANES; i++) begin
         e = predict_lane(i, wins[n], r.huff, r.nb, r.eob, wm);
         exp_mask[i] = (e.err != sdd_ld_pkg::ERR_NONE);
         if (e.err != sdd_ld_pkg::ERR_INVALID_CODE) begin
            check_eq($sformatf("lane%0d.sym", i), 64'(out_lanes[i].sym), 64'(e.sym));
         end
         check_eq($sformatf("lane%0d.len", i), 64'(out_lanes[i].len), 64'(e.len));
         check_eq($sformatf("lane%0d.err", i), 64'(out_lanes[i].err), 64'(e.err));
         check_eq($sformatf("lane%0d.eob", i), 64'(out_lanes[i].eob), 64'(e.eob));
         check_eq($sformatf("lane%0d.end_idx", i), 64'(out_lanes[i].end_idx), 64'(e.end_idx));
      end
      check_eq("out_err_mask", 64'(out_err_mask), 64'(exp_mask));
   endtask

   // Sample mid-cycle since a transfer happens at the next rising edge
   initial begin
      forever begin
         @(negedge clk);
         if (rst_n) begin
            if (!in_ready) last_hold = cyc;
            if (out_valid && out_ready) begin
               check_word(n_out);
               n_out = n_out + 1;
            end else begin
               check_eq("blk_done idle", 64'(blk_done), 64'd0);
            end
         end
      end
   end

   initial begin
      logic bp_now;
      forever begin
         @(posedge clk);
         bp_now = bp_mode; // Row mode from the cycle that just ended
         #5;
         out_ready = bp_now ? next_bit() : 1'b1;
      end
   end

   task automatic write_cfg(input sdd_ld_pkg::cfg_op_e op, input logic bank,
      input logic [4:0] idx, input logic [15:0] value);
      cfg.op    = op;
      cfg.bank  = bank;
      cfg.idx   = idx;
      cfg.value = value;
      cfg_stb   = 1'b1;
      @(posedge clk);
      #5;
      cfg_stb = 1'b0;
   endtask

   task automatic send_word(input int n);
      int waited;
      waited = 0;
      in_valid        = 1'b1;
      in_word.window  = wins[n];
      in_word.numbits = rows[n].nb;
      in_word.sob     = rows[n].sob;
      in_word.eob     = rows[n].eob;
      @(negedge clk);
      while (!in_ready) begin
         waited++;
         if (waited > 100) abort_run("Timed out waiting for in_ready to take a word");
         @(negedge clk);
      end
      acc_cyc[n] = cyc;
      @(posedge clk);
      #5;
      in_valid = 1'b0;
   endtask

   initial begin
      int waited;
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_word   = '0;
      cfg_stb   = 1'b0;
      cfg       = '0;
      out_ready = 1'b1;
      for (int r = 0; r < NROWS; r++) begin
         for (int b = 0; b < 40; b++) wins[r][b] = next_bit();
         if (rows[r].ones) wins[r] = '1;
      end
      repeat (4) @(posedge clk);
      #5;
      rst_n = 1'b1;
      @(negedge clk);
      check_eq("in_ready after reset", 64'(in_ready), 64'd1);
      check_eq("out_valid after reset", 64'(out_valid), 64'd0);
      @(posedge clk);
      #5;
      write_cfg(sdd_ld_pkg::CFG_FMT, 1'b0, 5'd0, 16'd1); // Bank 0 Huffman while bank 1 stays raw
      for (int l = 1; l <= 8; l++) begin
         write_cfg(sdd_ld_pkg::CFG_LEN, 1'b0, 5'(l), {8'(hf_first[l]), 8'(hf_count[l])});
      end
      for (int k = 0; k < 8; k++) write_cfg(sdd_ld_pkg::CFG_SYM, 1'b0, 5'(k), {8'd0, hf_sym[k]});
      for (int r = 0; r < NROWS; r++) begin
         bp_mode = rows[r].bp;
         send_word(r);
      end
      bp_mode = 1'b0;
      waited = 0;
      while (n_out < NROWS) begin
         @(negedge clk);
         waited++;
         if (waited > 200) abort_run("Timed out waiting for all words at the output");
      end
      repeat (10) @(negedge clk); // Room for a stray extra word to show up
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
